// ==== verilog/rs_pkg.sv ====
// Shared widths, counts and the ALU opcode enum, imported by every RTL file and the testbench
package rs_pkg;

    // Datapath
    localparam int data_width = 64;                // Operand and result width
    localparam int tag_width  = 5;                 // Producer tag width

    // Reservation station sizing
    localparam int rs_entries        = 4;          // Works with 2 to 8
    localparam int entry_index_width = $clog2(rs_entries);

    // Result stage
    localparam int queue_depth = 4;                // Caps ALU results queued or in flight
    localparam int alu_latency = 2;                // Issue edge to queue write, in cycles

    // ALU opcodes
    typedef enum logic [2:0] {
        alu_add  = 3'd0,                           // a + b
        alu_sub  = 3'd1,                           // a - b
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_sll  = 3'd5,                           // Shift left by b[5:0]
        alu_srl  = 3'd6,                           // Logical shift right by b[5:0]
        alu_sltu = 3'd7                            // Unsigned a < b, zero extended
    } alu_op_t;

endpackage

// ==== verilog/dispatch_decode.sv ====
// Dispatch decode: picks the lowest free reservation station entry and bypasses the CDB into operands
`timescale 1ns/1ps

module dispatch_decode (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 dispatch_valid,     // One-cycle strobe
    input  rs_pkg::alu_op_t                      dispatch_op,
    input  logic [rs_pkg::tag_width-1:0]         dispatch_dest_tag,
    input  logic [rs_pkg::data_width-1:0]        opa_value,          // Value or waited tag
    input  logic                                 opa_valid,
    input  logic [rs_pkg::data_width-1:0]        opb_value,
    input  logic                                 opb_valid,
    input  logic [rs_pkg::rs_entries-1:0]        entry_busy,
    input  logic                                 cdb_valid,
    input  logic [rs_pkg::tag_width-1:0]         cdb_tag,
    input  logic [rs_pkg::data_width-1:0]        cdb_value,
    output logic                                 alloc_valid,
    output logic [rs_pkg::entry_index_width-1:0] alloc_index,
    output rs_pkg::alu_op_t                      alloc_op,
    output logic [rs_pkg::tag_width-1:0]         alloc_dest_tag,
    output logic [rs_pkg::data_width-1:0]        alloc_opa,
    output logic                                 alloc_opa_valid,
    output logic [rs_pkg::data_width-1:0]        alloc_opb,
    output logic                                 alloc_opb_valid,
    output logic                                 rs_full
);
    import rs_pkg::*;

    logic hit_a;                                   // Operand a tag is on the CDB right now
    logic hit_b;

    // True when an operand still waits and its tag is being broadcast
    function automatic logic cdb_hit(input logic [data_width-1:0] value, input logic valid);
        return cdb_valid && !valid && (cdb_tag == value[tag_width-1:0]);
    endfunction

    assign rs_full = &entry_busy;                  // No free entry left

    // Lowest free entry wins, scan from the top so index 0 ends up last
    always_comb
    begin
        alloc_index = '0;
        for (int i = rs_entries - 1; i >= 0; i--)
        begin
            if (!entry_busy[i])
                alloc_index = entry_index_width'(i);
        end
    end

    assign alloc_valid    = dispatch_valid && !rs_full;
    assign alloc_op       = dispatch_op;
    assign alloc_dest_tag = dispatch_dest_tag;

    // Same-cycle bypass, the entry would miss this broadcast otherwise
    assign hit_a           = cdb_hit(opa_value, opa_valid);
    assign hit_b           = cdb_hit(opb_value, opb_valid);
    assign alloc_opa       = hit_a ? cdb_value : opa_value;
    assign alloc_opa_valid = opa_valid || hit_a;
    assign alloc_opb       = hit_b ? cdb_value : opb_value;
    assign alloc_opb_valid = opb_valid || hit_b;

    // Caller may only dispatch while a slot is free
    dispatch_not_full: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !rs_full);

endmodule

// ==== verilog/rs_entry.sv ====
// One reservation station entry: holds an operation, snoops the CDB for its operands, frees on issue
`timescale 1ns/1ps

module rs_entry (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          load,            // Write a new operation
    input  rs_pkg::alu_op_t               load_op,
    input  logic [rs_pkg::tag_width-1:0]  load_dest_tag,
    input  logic [rs_pkg::data_width-1:0] load_opa,        // Value or waited tag
    input  logic                          load_opa_valid,
    input  logic [rs_pkg::data_width-1:0] load_opb,
    input  logic                          load_opb_valid,
    input  logic                          cdb_valid,
    input  logic [rs_pkg::tag_width-1:0]  cdb_tag,
    input  logic [rs_pkg::data_width-1:0] cdb_value,
    input  logic                          use_enable,      // Issued this cycle, free the slot
    output logic                          busy,            // Entry in use
    output logic                          ready,           // In use with both operands present
    output rs_pkg::alu_op_t               op,
    output logic [rs_pkg::data_width-1:0] opa,
    output logic [rs_pkg::data_width-1:0] opb,
    output logic [rs_pkg::tag_width-1:0]  dest_tag
);
    import rs_pkg::*;

    logic opa_valid;                               // Low means opa holds a tag
    logic opb_valid;
    logic capture_a;                               // Waited tag for a is on the CDB
    logic capture_b;

    assign capture_a = cdb_valid && busy && !opa_valid && (cdb_tag == opa[tag_width-1:0]);
    assign capture_b = cdb_valid && busy && !opb_valid && (cdb_tag == opb[tag_width-1:0]);
    assign ready     = busy && opa_valid && opb_valid;

    // Control state
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end
        else if (load)
        begin
            busy      <= 1'b1;
            opa_valid <= load_opa_valid;
            opb_valid <= load_opb_valid;
        end
        else
        begin
            if (use_enable)
                busy <= 1'b0;                      // Data has left for the ALU
            if (capture_a)
                opa_valid <= 1'b1;
            if (capture_b)
                opb_valid <= 1'b1;
        end
    end

    // Payload
    always_ff @(posedge clock)
    begin
        if (load)
        begin
            op       <= load_op;
            dest_tag <= load_dest_tag;
            opa      <= load_opa;
            opb      <= load_opb;
        end
        else
        begin
            if (capture_a)
                opa <= cdb_value;                  // Tag replaced by the broadcast result
            if (capture_b)
                opb <= cdb_value;
        end
    end

    // Decode only targets free entries
    load_when_free: assert property (@(posedge clock) disable iff (reset) load |-> !busy);

endmodule

// ==== verilog/rs_array.sv ====
// Reservation station array holding the entries and picking the lowest-index ready one for issue
`timescale 1ns/1ps

module rs_array (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 alloc_valid,
    input  logic [rs_pkg::entry_index_width-1:0] alloc_index,
    input  rs_pkg::alu_op_t                      alloc_op,
    input  logic [rs_pkg::tag_width-1:0]         alloc_dest_tag,
    input  logic [rs_pkg::data_width-1:0]        alloc_opa,
    input  logic                                 alloc_opa_valid,
    input  logic [rs_pkg::data_width-1:0]        alloc_opb,
    input  logic                                 alloc_opb_valid,
    input  logic                                 cdb_valid,
    input  logic [rs_pkg::tag_width-1:0]         cdb_tag,
    input  logic [rs_pkg::data_width-1:0]        cdb_value,
    input  logic                                 issue_hold,     // Result queue has no credit
    output logic [rs_pkg::rs_entries-1:0]        entry_busy,
    output logic                                 issue_valid,
    output rs_pkg::alu_op_t                      issue_op,
    output logic [rs_pkg::data_width-1:0]        issue_opa,
    output logic [rs_pkg::data_width-1:0]        issue_opb,
    output logic [rs_pkg::tag_width-1:0]         issue_tag
);
    import rs_pkg::*;

    logic [rs_entries-1:0]        entry_ready;
    logic [rs_entries-1:0]        grant;                       // Per-entry use_enable
    logic [entry_index_width-1:0] issue_index;
    logic                         any_ready;
    alu_op_t                      entry_op  [rs_entries];
    logic [data_width-1:0]        entry_opa [rs_entries];
    logic [data_width-1:0]        entry_opb [rs_entries];
    logic [tag_width-1:0]         entry_tag [rs_entries];

    for (genvar i = 0; i < rs_entries; i++)
    begin : g_entry
        rs_entry entry_inst (
            .clock          (clock),
            .reset          (reset),
            .load           (alloc_valid && (alloc_index == entry_index_width'(i))),
            .load_op        (alloc_op),
            .load_dest_tag  (alloc_dest_tag),
            .load_opa       (alloc_opa),
            .load_opa_valid (alloc_opa_valid),
            .load_opb       (alloc_opb),
            .load_opb_valid (alloc_opb_valid),
            .cdb_valid      (cdb_valid),
            .cdb_tag        (cdb_tag),
            .cdb_value      (cdb_value),
            .use_enable     (grant[i]),
            .busy           (entry_busy[i]),
            .ready          (entry_ready[i]),
            .op             (entry_op[i]),
            .opa            (entry_opa[i]),
            .opb            (entry_opb[i]),
            .dest_tag       (entry_tag[i])
        );
    end

    // Lowest ready index wins the issue slot
    always_comb
    begin
        issue_index = '0;
        any_ready   = 1'b0;
        for (int i = 0; i < rs_entries; i++)
        begin
            if (entry_ready[i] && !any_ready)
            begin
                any_ready   = 1'b1;
                issue_index = entry_index_width'(i);
            end
        end
        issue_valid = any_ready && !issue_hold;    // Held entries stay occupied
        grant       = '0;
        if (issue_valid)
            grant[issue_index] = 1'b1;
    end

    // Issue multiplexer
    assign issue_op  = entry_op[issue_index];
    assign issue_opa = entry_opa[issue_index];
    assign issue_opb = entry_opb[issue_index];
    assign issue_tag = entry_tag[issue_index];

    // Single ALU port means at most one entry frees per cycle
    single_issue: assert property (@(posedge clock) disable iff (reset)
        $onehot0($past(entry_busy) & ~entry_busy));

endmodule

// ==== verilog/alu_execute.sv ====
// Two-stage 64-bit integer ALU: operands latched on issue, result registered one cycle later
`timescale 1ns/1ps

module alu_execute (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    input  rs_pkg::alu_op_t               issue_op,
    input  logic [rs_pkg::data_width-1:0] issue_opa,
    input  logic [rs_pkg::data_width-1:0] issue_opb,
    input  logic [rs_pkg::tag_width-1:0]  issue_tag,
    output logic                          alu_valid,
    output logic [rs_pkg::tag_width-1:0]  alu_tag,
    output logic [rs_pkg::data_width-1:0] alu_value
);
    import rs_pkg::*;

    logic [alu_latency-1:0] valid_pipe;            // Bit 0 is stage one
    logic [tag_width-1:0]   tag_pipe [alu_latency];
    alu_op_t                s1_op;
    logic [data_width-1:0]  s1_a;
    logic [data_width-1:0]  s1_b;
    logic [data_width-1:0]  s1_result;

    always_ff @(posedge clock)
    begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[alu_latency-2:0], issue_valid};
    end

    // Tag rides alongside its valid bit
    always_ff @(posedge clock)
    begin
        tag_pipe[0] <= issue_tag;
        for (int i = 1; i < alu_latency; i++)
            tag_pipe[i] <= tag_pipe[i-1];
    end

    // Stage one operand latch
    always_ff @(posedge clock)
    begin
        if (issue_valid)
        begin
            s1_op <= issue_op;
            s1_a  <= issue_opa;
            s1_b  <= issue_opb;
        end
    end

    always_comb
    begin
        unique case (s1_op)
            alu_add:  s1_result = s1_a + s1_b;
            alu_sub:  s1_result = s1_a - s1_b;
            alu_and:  s1_result = s1_a & s1_b;
            alu_or:   s1_result = s1_a | s1_b;
            alu_xor:  s1_result = s1_a ^ s1_b;
            alu_sll:  s1_result = s1_a << s1_b[5:0];                 // Shift amount in low 6 bits
            alu_srl:  s1_result = s1_a >> s1_b[5:0];
            alu_sltu: s1_result = {{(data_width-1){1'b0}}, s1_a < s1_b};
            default:  s1_result = '0;
        endcase
    end

    // Stage two result register
    always_ff @(posedge clock)
    begin
        if (valid_pipe[0])
            alu_value <= s1_result;
    end

    assign alu_valid = valid_pipe[alu_latency-1];
    assign alu_tag   = tag_pipe[alu_latency-1];

endmodule

// ==== verilog/cdb_result.sv ====
// Result stage: queues ALU results, lets outside results win, drives the registered CDB and issue credit
`timescale 1ns/1ps

module cdb_result (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,      // Takes one credit
    input  logic                          alu_valid,
    input  logic [rs_pkg::tag_width-1:0]  alu_tag,
    input  logic [rs_pkg::data_width-1:0] alu_value,
    input  logic                          ext_result_valid, // Always accepted
    input  logic [rs_pkg::tag_width-1:0]  ext_result_tag,
    input  logic [rs_pkg::data_width-1:0] ext_result_value,
    output logic                          issue_hold,
    output logic                          cdb_valid,
    output logic [rs_pkg::tag_width-1:0]  cdb_tag,
    output logic [rs_pkg::data_width-1:0] cdb_value
);
    import rs_pkg::*;

    logic [tag_width-1:0]             q_tag   [queue_depth];
    logic [data_width-1:0]            q_value [queue_depth];
    logic [$clog2(queue_depth)-1:0]   wr_ptr;                 // Wraps naturally, depth is 2^n
    logic [$clog2(queue_depth)-1:0]   rd_ptr;
    logic [$clog2(queue_depth+1)-1:0] q_count;
    logic [$clog2(queue_depth+1)-1:0] credit;                 // Queued plus in flight
    logic                             pop;                    // Queue head goes out this cycle

    assign pop        = !ext_result_valid && (q_count != '0);
    assign issue_hold = (int'(credit) == queue_depth);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            credit    <= '0;
            cdb_valid <= 1'b0;
        end
        else
        begin
            if (alu_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({alu_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            case ({issue_valid, pop})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;             // Returned on broadcast
                default: credit <= credit;
            endcase
            cdb_valid <= ext_result_valid || pop;
        end
    end

    // Queue storage and CDB payload
    always_ff @(posedge clock)
    begin
        if (alu_valid)
        begin
            q_tag[wr_ptr]   <= alu_tag;
            q_value[wr_ptr] <= alu_value;
        end
        cdb_tag   <= ext_result_valid ? ext_result_tag : q_tag[rd_ptr];
        cdb_value <= ext_result_valid ? ext_result_value : q_value[rd_ptr];
    end

    credit_bound: assert property (@(posedge clock) disable iff (reset)
        int'(credit) <= queue_depth);

    no_overflow: assert property (@(posedge clock) disable iff (reset)
        alu_valid |-> int'(q_count) < queue_depth);

    // Credit accounting relies on every issue returning after a fixed delay
    alu_returns: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> ##alu_latency alu_valid);

endmodule

// ==== verilog/rs_top.sv ====
// Top level of the reservation station slice: dispatch decode, entry array, ALU and CDB result stage
`timescale 1ns/1ps

module rs_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          dispatch_valid,
    input  rs_pkg::alu_op_t               dispatch_op,
    input  logic [rs_pkg::tag_width-1:0]  dispatch_dest_tag,
    input  logic [rs_pkg::data_width-1:0] opa_value,
    input  logic                          opa_valid,
    input  logic [rs_pkg::data_width-1:0] opb_value,
    input  logic                          opb_valid,
    input  logic                          ext_result_valid,
    input  logic [rs_pkg::tag_width-1:0]  ext_result_tag,
    input  logic [rs_pkg::data_width-1:0] ext_result_value,
    output logic                          cdb_valid,
    output logic [rs_pkg::tag_width-1:0]  cdb_tag,
    output logic [rs_pkg::data_width-1:0] cdb_value,
    output logic                          rs_full
);
    import rs_pkg::*;

    logic                         alloc_valid;
    logic [entry_index_width-1:0] alloc_index;
    alu_op_t                      alloc_op;
    logic [tag_width-1:0]         alloc_dest_tag;
    logic [data_width-1:0]        alloc_opa;
    logic                         alloc_opa_valid;
    logic [data_width-1:0]        alloc_opb;
    logic                         alloc_opb_valid;
    logic [rs_entries-1:0]        entry_busy;
    logic                         issue_valid;
    alu_op_t                      issue_op;
    logic [data_width-1:0]        issue_opa;
    logic [data_width-1:0]        issue_opb;
    logic [tag_width-1:0]         issue_tag;
    logic                         issue_hold;
    logic                         alu_valid;
    logic [tag_width-1:0]         alu_tag;
    logic [data_width-1:0]        alu_value;

    dispatch_decode decode_inst (
        .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_dest_tag,
        .opa_value, .opa_valid, .opb_value, .opb_valid, .entry_busy,
        .cdb_valid, .cdb_tag, .cdb_value,
        .alloc_valid, .alloc_index, .alloc_op, .alloc_dest_tag,
        .alloc_opa, .alloc_opa_valid, .alloc_opb, .alloc_opb_valid, .rs_full
    );

    rs_array array_inst (
        .clock, .reset, .alloc_valid, .alloc_index, .alloc_op, .alloc_dest_tag,
        .alloc_opa, .alloc_opa_valid, .alloc_opb, .alloc_opb_valid,
        .cdb_valid, .cdb_tag, .cdb_value, .issue_hold, .entry_busy,
        .issue_valid, .issue_op, .issue_opa, .issue_opb, .issue_tag
    );

    alu_execute alu_inst (
        .clock, .reset, .issue_valid, .issue_op, .issue_opa, .issue_opb, .issue_tag,
        .alu_valid, .alu_tag, .alu_value
    );

    cdb_result result_inst (
        .clock, .reset, .issue_valid, .alu_valid, .alu_tag, .alu_value,
        .ext_result_valid, .ext_result_tag, .ext_result_value,
        .issue_hold, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

// ==== tests/rs_model.svh ====
// Testbench reference model with expected ALU results, the xorshift generator and the value check
`ifndef rs_model_svh
`define rs_model_svh

// Expected result worked out from the opcode definitions
function automatic logic [data_width-1:0] alu_ref(input alu_op_t op,
                                                 input logic [data_width-1:0] a,
                                                 input logic [data_width-1:0] b);
    logic [data_width-1:0] result;
    case (op)
        alu_add:  result = a + b;
        alu_sub:  result = a + ~b + data_width'(1);          // Two's complement subtract
        alu_and:  result = a & b;
        alu_or:   result = a | b;
        alu_xor:  result = a ^ b;
        alu_sll:  result = a * (data_width'(1) << b[5:0]);   // Multiply by a power of two
        alu_srl:  result = a >> b[5:0];
        default:  result = data_width'(a < b);               // Unsigned compare, 0 or 1
    endcase
    return result;
endfunction

// One xorshift step, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Compares an observed value with the expected one, stops at the first mismatch
task automatic check_value(input logic [data_width-1:0] actual,
                           input logic [data_width-1:0] expected,
                           input string what);
    if (actual !== expected)
        abort_run($sformatf("** Error at time %0t: %s, got %h, expected %h",
                            $time, what, actual, expected));
endtask

`endif

// ==== tests/rs_tb.sv ====
// Testbench for rs_top that drives random dispatches and outside results and checks each CDB beat
`timescale 1ns/1ps

module rs_tb;
    import rs_pkg::*;

    localparam int clock_period    = 100;
    localparam int reset_cycles    = 8;
    localparam int tag_count       = 1 << tag_width;
    localparam int alu_tags        = tag_count / 2;            // Low half for ALU ops
    localparam int value_ops       = 40;                       // Operands as values only
    localparam int dep_ops         = 80;                       // Operands waiting on tags
    localparam int dense_ops       = 40;                       // Under dense outside results
    localparam int total_ops       = value_ops + dep_ops + dense_ops + rs_entries + 400;
    localparam int cycles_per_op   = 30;                       // Covers queue stalls
    localparam int watchdog_cycles = total_ops * cycles_per_op + 500;
    localparam logic [1:0] st_free      = 2'd0;
    localparam logic [1:0] st_announced = 2'd1;                // Outside tag known but not yet driven
    localparam logic [1:0] st_pending   = 2'd2;                // Waiting for its CDB beat

    logic                  clock;
    logic                  reset;
    logic                  dispatch_valid;
    logic                  opa_valid;
    logic                  opb_valid;
    logic                  ext_result_valid;
    logic                  cdb_valid;
    logic                  rs_full;
    alu_op_t               dispatch_op;
    logic [tag_width-1:0]  dispatch_dest_tag;
    logic [tag_width-1:0]  ext_result_tag;
    logic [tag_width-1:0]  cdb_tag;
    logic [data_width-1:0] opa_value;
    logic [data_width-1:0] opb_value;
    logic [data_width-1:0] ext_result_value;
    logic [data_width-1:0] cdb_value;

    logic [1:0]            tag_state [tag_count];
    alu_op_t               sb_op     [tag_count];
    logic [data_width-1:0] sb_a      [tag_count];              // Value or waited tag while unknown
    logic [data_width-1:0] sb_b      [tag_count];
    logic [data_width-1:0] ext_value [tag_count];
    logic                  a_known   [tag_count];
    logic                  b_known   [tag_count];
    logic [31:0]           rng_state;
    int                    busy_tags;                          // Tags not yet broadcast
    int                    withheld;                           // Outside tag held back to fill the entries
    int                    ops_sent;

    `include "rs_model.svh"

    rs_top rs_top_inst (.*);

    always #(clock_period / 2) clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = rand32();
        return int'(r % 32'd100) < pct;
    endfunction

    // Random tag of one half in the given state or -1 when none is left
    function automatic int pick_tag(input int base, input logic [1:0] state);
        logic [31:0] r;
        int          t;
        int          found;
        r     = rand32();
        found = -1;
        for (int i = 0; i < alu_tags; i++)
        begin
            t = base + (int'(r[15:0]) + i) % alu_tags;
            if (found < 0 && tag_state[t] == state)
                found = t;
        end
        return found;
    endfunction

    // Waited operand source that favours the tag on the CDB right now to hit the bypass
    function automatic int pick_source();
        int found;
        found = -1;
        if (cdb_valid && tag_state[cdb_tag] == st_pending && chance(50))
            found = int'(cdb_tag);
        for (int i = 0; i < tag_count && found < 0; i++)
            if (tag_state[i] != st_free && chance(20))
                found = i;
        return found;
    endfunction

    task automatic choose_operand(input int wait_pct, input int force_src,
                                  output logic [data_width-1:0] value, output logic valid);
        int src;
        src = force_src;
        if (src < 0 && chance(wait_pct))
            src = pick_source();
        valid = (src < 0);
        value = valid ? {rand32(), rand32()} : data_width'(src);  // Low bits carry the tag
    endtask

    task automatic dispatch_one(input int wait_pct, input int force_src);
        int          t;
        logic [31:0] r;
        t = pick_tag(0, st_free);
        r = rand32();
        if (t >= 0)
        begin
            choose_operand(wait_pct, force_src, opa_value, opa_valid);
            choose_operand(wait_pct, -1, opb_value, opb_valid);
            dispatch_valid    = 1'b1;
            dispatch_op       = alu_op_t'(r[2:0]);
            dispatch_dest_tag = tag_width'(t);
            sb_op[t]          = dispatch_op;
            sb_a[t]           = opa_value;
            a_known[t]        = opa_valid;
            sb_b[t]           = opb_value;
            b_known[t]        = opb_valid;
            tag_state[t]      = st_pending;
            busy_tags++;
            ops_sent++;
        end
    endtask

    task automatic send_ext(input int t);
        ext_result_valid = 1'b1;
        ext_result_tag   = tag_width'(t);
        ext_result_value = ext_value[t];
        tag_state[t]     = st_pending;
    endtask

    task automatic begin_cycle();
        @(negedge clock);
        dispatch_valid   = 1'b0;
        ext_result_valid = 1'b0;
    endtask

    // One cycle of outside producer and dispatch traffic
    task automatic run_cycle(input int dispatch_pct, input int wait_pct,
                             input int send_pct, input int announce_pct);
        int t;
        begin_cycle();
        t = pick_tag(alu_tags, st_announced);
        if (t >= 0 && chance(send_pct))
            send_ext(t);
        t = pick_tag(alu_tags, st_free);
        if (t >= 0 && chance(announce_pct))
        begin
            tag_state[t] = st_announced;
            ext_value[t] = {rand32(), rand32()};
            busy_tags++;
        end
        if (!rs_full && chance(dispatch_pct))
            dispatch_one(wait_pct, -1);
    endtask

    task automatic drain();
        while (busy_tags != 0)
            run_cycle(0, 0, 50, 0);
    endtask

    // Operands that waited on src now hold its broadcast value
    task automatic resolve_waiters(input logic [tag_width-1:0] src,
                                   input logic [data_width-1:0] value);
        for (int t = 0; t < alu_tags; t++)
        begin
            if (tag_state[t] == st_pending && !a_known[t] && sb_a[t][tag_width-1:0] == src)
            begin
                sb_a[t]    = value;
                a_known[t] = 1'b1;
            end
            if (tag_state[t] == st_pending && !b_known[t] && sb_b[t][tag_width-1:0] == src)
            begin
                sb_b[t]    = value;
                b_known[t] = 1'b1;
            end
        end
    endtask

    // CDB monitor sees the beat of the cycle that ends at this edge
    always @(posedge clock)
    begin
        int t;
        t = int'(cdb_tag);
        if (!reset && cdb_valid)
        begin
            if (tag_state[t] != st_pending)
                abort_run($sformatf("tag %0d was broadcast without waiting for a result", t));
            else if (t < alu_tags && !(a_known[t] && b_known[t]))
                abort_run($sformatf("tag %0d was broadcast before its operands arrived", t));
            else
            begin
                check_value(cdb_value,
                            (t < alu_tags) ? alu_ref(sb_op[t], sb_a[t], sb_b[t]) : ext_value[t],
                            $sformatf("value of tag %0d", t));
                tag_state[t] = st_free;
                busy_tags--;
                resolve_waiters(cdb_tag, cdb_value);
            end
        end
    end

    initial
    begin
        #(watchdog_cycles * clock_period);
        abort_run("watchdog expired before every dispatched tag was broadcast");
    end

    initial
    begin
        clock             = 1'b0;
        reset             = 1'b1;
        dispatch_valid    = 1'b0;
        dispatch_op       = alu_add;
        dispatch_dest_tag = '0;
        opa_value         = '0;
        opa_valid         = 1'b0;
        opb_value         = '0;
        opb_valid         = 1'b0;
        ext_result_valid  = 1'b0;
        ext_result_tag    = '0;
        ext_result_value  = '0;
        rng_state         = 32'h3f093132;
        tag_state         = '{default: st_free};
        busy_tags         = 0;
        ops_sent          = 0;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        repeat (10)
        begin
            run_cycle(0, 0, 0, 0);
            check_value(data_width'(cdb_valid), '0, "cdb_valid with no stimulus");
            check_value(data_width'(rs_full), '0, "rs_full with no stimulus");
        end
        while (ops_sent < value_ops)
            run_cycle(60, 0, 0, 0);
        drain();
        while (ops_sent < value_ops + dep_ops)
            run_cycle(60, 70, 40, 40);
        drain();
        while (ops_sent < value_ops + dep_ops + dense_ops)
            run_cycle(50, 40, 90, 90);                             // Outside results nearly every cycle
        drain();
        withheld               = alu_tags;                         // Every entry waits on this tag
        tag_state[withheld]    = st_announced;
        ext_value[withheld]    = {rand32(), rand32()};
        busy_tags++;
        for (int i = 0; i < 4 * rs_entries && !rs_full; i++)
        begin
            begin_cycle();
            if (!rs_full)
                dispatch_one(0, withheld);
        end
        repeat (4)
        begin
            begin_cycle();
            check_value(data_width'(rs_full), data_width'(1), "rs_full while the tag is held back");
        end
        begin_cycle();
        send_ext(withheld);
        drain();
        check_value(data_width'(rs_full), '0, "rs_full after the held tag was broadcast");
        while (ops_sent < total_ops)
            run_cycle(45, 40, 35, 35);
        drain();
        repeat (5)
        begin
            begin_cycle();
            check_value(data_width'(rs_full), '0, "rs_full after the run drained");
            check_value(data_width'(cdb_valid), '0, "cdb_valid after the run drained");
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+tests
verilog/rs_pkg.sv
verilog/dispatch_decode.sv
verilog/rs_entry.sv
verilog/rs_array.sv
verilog/alu_execute.sv
verilog/cdb_result.sv
verilog/rs_top.sv
tests/rs_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = rs_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
COMMON     = --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary $(COMMON) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
